/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// Data memory depth in 32-bit words
`define DMEM_WORDS 256

`endif

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // ALU operation codes, compare-only codes sit at the end
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B,   // LUI
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_type_e;

    // Encoded as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4
    } wb_src_e;

endpackage

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module control_unit import cpu_pkg::*; (
    input  logic [`XLEN-1:0]       instr_i,
    input  logic                   branch_flag_i,
    output logic [`REG_ADDR_W-1:0] rs1_o,
    output logic [`REG_ADDR_W-1:0] rs2_o,
    output logic [`REG_ADDR_W-1:0] rd_o,
    output logic [`XLEN-1:0]       imm_o,
    output alu_op_e                alu_op_o,
    output logic                   alu_a_pc_o,
    output logic                   alu_b_imm_o,
    output wb_src_e                wb_src_o,
    output logic                   reg_we_o,
    output logic                   mem_we_o,
    output mem_size_e              mem_size_o,
    output logic                   mem_unsigned_o,
    output logic                   pc_branch_o,
    output logic                   pc_jalr_o
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    imm_type_e  imm_type;

    // Register-register and register-immediate ALU group
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    assign mem_size_o     = mem_size_e'(funct3[1:0]);  // LB/LH/LW and SB/SH/SW
    assign mem_unsigned_o = funct3[2];                 // LBU, LHU

    always_comb begin
        alu_op_o    = ALU_ADD;
        alu_a_pc_o  = 1'b0;
        alu_b_imm_o = 1'b0;
        wb_src_o    = WB_ALU;
        reg_we_o    = 1'b0;
        mem_we_o    = 1'b0;
        pc_branch_o = 1'b0;
        pc_jalr_o   = 1'b0;
        imm_type    = IMM_I;
        case (opcode)
            OPC_LUI: begin
                imm_type    = IMM_U;
                alu_op_o    = ALU_PASS_B;
                alu_b_imm_o = 1'b1;
                reg_we_o    = 1'b1;
            end
            OPC_AUIPC: begin
                imm_type    = IMM_U;
                alu_a_pc_o  = 1'b1;
                alu_b_imm_o = 1'b1;
                reg_we_o    = 1'b1;
            end
            OPC_JAL: begin
                imm_type    = IMM_J;
                wb_src_o    = WB_PC_PLUS4;
                reg_we_o    = 1'b1;
                pc_branch_o = 1'b1;       // Always taken
            end
            OPC_JALR: begin
                alu_b_imm_o = 1'b1;       // rs1 + imm, bit 0 cleared in pc_unit
                wb_src_o    = WB_PC_PLUS4;
                reg_we_o    = 1'b1;
                pc_jalr_o   = 1'b1;
            end
            OPC_BRANCH: begin
                imm_type    = IMM_B;
                pc_branch_o = branch_flag_i;
                case (funct3)
                    3'b000:  alu_op_o = ALU_EQ;
                    3'b001:  alu_op_o = ALU_NE;
                    3'b100:  alu_op_o = ALU_LT;
                    3'b101:  alu_op_o = ALU_GE;
                    3'b110:  alu_op_o = ALU_LTU;
                    default: alu_op_o = ALU_GEU;
                endcase
            end
            OPC_LOAD: begin
                alu_b_imm_o = 1'b1;
                wb_src_o    = WB_MEM;
                reg_we_o    = 1'b1;
            end
            OPC_STORE: begin
                imm_type    = IMM_S;
                alu_b_imm_o = 1'b1;
                mem_we_o    = 1'b1;
            end
            OPC_OP_IMM: begin
                // Only SRAI uses funct7, ADDI has no subtract form
                alu_op_o    = arith_op(funct3, (funct3 == 3'b101) && instr_i[30]);
                alu_b_imm_o = 1'b1;
                reg_we_o    = 1'b1;
            end
            OPC_OP: begin
                alu_op_o = arith_op(funct3, instr_i[30]);
                reg_we_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        case (imm_type)
            IMM_S:   imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:   imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                              instr_i[11:8], 1'b0};
            IMM_U:   imm_o = {instr_i[31:12], 12'b0};
            IMM_J:   imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                              instr_i[30:21], 1'b0};
            default: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module register_file (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic [`REG_ADDR_W-1:0] rs1_i,
    input  logic [`REG_ADDR_W-1:0] rs2_i,
    input  logic [`REG_ADDR_W-1:0] rd_i,
    input  logic                   we_i,
    input  logic [`XLEN-1:0]       wd_i,
    output logic [`XLEN-1:0]       rd1_o,
    output logic [`XLEN-1:0]       rd2_o
);

    localparam int NREGS = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [1:NREGS-1];   // x0 has no storage

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module alu import cpu_pkg::*; (
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    input  alu_op_e          op_i,
    output logic [`XLEN-1:0] result_o,
    output logic             flag_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b_i[4:0];   // RV32 shifts use 5 bits only
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;
    assign eq    = a_i == b_i;

    always_comb begin
        result_o = '0;
        flag_o   = 1'b0;
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_SLT:    result_o = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result_o = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_PASS_B: result_o = b_i;
            ALU_EQ:     flag_o   = eq;
            ALU_NE:     flag_o   = !eq;
            ALU_LT:     flag_o   = lt_s;
            ALU_GE:     flag_o   = !lt_s;
            ALU_LTU:    flag_o   = lt_u;
            ALU_GEU:    flag_o   = !lt_u;
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/pc_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module pc_unit (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic [`XLEN-1:0] imm_i,
    input  logic [`XLEN-1:0] jalr_target_i,
    input  logic             branch_i,
    input  logic             jalr_i,
    output logic [`XLEN-1:0] pc_o,
    output logic [`XLEN-1:0] pc_plus4_o
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_target;
    logic [`XLEN-1:0] next_pc;

    assign pc_plus4_o = pc + `XLEN'd4;
    assign pc_target  = pc + imm_i;        // Branch and JAL target

    always_comb begin
        if (jalr_i) begin
            next_pc = {jalr_target_i[`XLEN-1:1], 1'b0};
        end else if (branch_i) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4_o;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign pc_o = pc;

endmodule

`default_nettype wire

/* verilog/data_memory.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module data_memory import cpu_pkg::*; (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic [`XLEN-1:0] addr_i,
    input  logic [`XLEN-1:0] wdata_i,
    input  logic             we_i,
    input  mem_size_e        size_i,
    input  logic             unsigned_i,
    output logic [`XLEN-1:0] rdata_o
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [0:`DMEM_WORDS-1];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       offset;
    logic [3:0]       byte_en;
    logic [`XLEN-1:0] wlanes;
    logic [`XLEN-1:0] rword;
    logic [7:0]       rbyte;
    logic [15:0]      rhalf;

    assign word_idx = addr_i[IDX_W+1:2];
    assign offset   = addr_i[1:0];

    // Byte lanes and replicated store data
    always_comb begin
        case (size_i)
            MEM_BYTE: begin
                byte_en = 4'b0001 << offset;
                wlanes  = {4{wdata_i[7:0]}};
            end
            MEM_HALF: begin
                byte_en = 4'b0011 << {offset[1], 1'b0};
                wlanes  = {2{wdata_i[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wlanes  = wdata_i;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (we_i && arst_n_i) begin   // No stores during reset
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wlanes[8*b +: 8];
                end
            end
        end
    end

    assign rword = mem[word_idx];
    assign rbyte = rword[8*offset +: 8];
    assign rhalf = rword[16*offset[1] +: 16];

    always_comb begin
        case (size_i)
            MEM_BYTE: rdata_o = {{24{rbyte[7] & !unsigned_i}}, rbyte};
            MEM_HALF: rdata_o = {{16{rhalf[15] & !unsigned_i}}, rhalf};
            default:  rdata_o = rword;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    output logic [`XLEN-1:0]       imem_addr_o,
    input  logic [`XLEN-1:0]       imem_data_i,
    output logic                   wb_en_o,
    output logic [`REG_ADDR_W-1:0] wb_rd_o,
    output logic [`XLEN-1:0]       wb_data_o
);

    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    alu_op_e                alu_op;
    logic                   alu_a_pc;      // Operand A from PC (AUIPC)
    logic                   alu_b_imm;     // Operand B from immediate
    wb_src_e                wb_src;
    logic                   reg_we;
    logic                   mem_we;
    mem_size_e              mem_size;
    logic                   mem_unsigned;
    logic                   pc_branch;
    logic                   pc_jalr;
    logic                   branch_flag;
    logic [`XLEN-1:0]       rd1;
    logic [`XLEN-1:0]       rd2;
    logic [`XLEN-1:0]       alu_a;
    logic [`XLEN-1:0]       alu_b;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       mem_rdata;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       pc_plus4;
    logic [`XLEN-1:0]       wb_data;

    control_unit i_control_unit (
        .instr_i        ( imem_data_i  ),
        .branch_flag_i  ( branch_flag  ),
        .rs1_o          ( rs1          ),
        .rs2_o          ( rs2          ),
        .rd_o           ( rd           ),
        .imm_o          ( imm          ),
        .alu_op_o       ( alu_op       ),
        .alu_a_pc_o     ( alu_a_pc     ),
        .alu_b_imm_o    ( alu_b_imm    ),
        .wb_src_o       ( wb_src       ),
        .reg_we_o       ( reg_we       ),
        .mem_we_o       ( mem_we       ),
        .mem_size_o     ( mem_size     ),
        .mem_unsigned_o ( mem_unsigned ),
        .pc_branch_o    ( pc_branch    ),
        .pc_jalr_o      ( pc_jalr      )
    );

    register_file i_register_file (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .rs1_i    ( rs1      ),
        .rs2_i    ( rs2      ),
        .rd_i     ( rd       ),
        .we_i     ( reg_we   ),
        .wd_i     ( wb_data  ),
        .rd1_o    ( rd1      ),
        .rd2_o    ( rd2      )
    );

    assign alu_a = alu_a_pc  ? pc  : rd1;
    assign alu_b = alu_b_imm ? imm : rd2;

    alu i_alu (
        .a_i      ( alu_a       ),
        .b_i      ( alu_b       ),
        .op_i     ( alu_op      ),
        .result_o ( alu_result  ),
        .flag_o   ( branch_flag )
    );

    pc_unit i_pc_unit (
        .clk_i         ( clk_i      ),
        .arst_n_i      ( arst_n_i   ),
        .imm_i         ( imm        ),
        .jalr_target_i ( alu_result ),
        .branch_i      ( pc_branch  ),
        .jalr_i        ( pc_jalr    ),
        .pc_o          ( pc         ),
        .pc_plus4_o    ( pc_plus4   )
    );

    data_memory i_data_memory (
        .clk_i      ( clk_i        ),
        .arst_n_i   ( arst_n_i     ),
        .addr_i     ( alu_result   ),
        .wdata_i    ( rd2          ),
        .we_i       ( mem_we       ),
        .size_i     ( mem_size     ),
        .unsigned_i ( mem_unsigned ),
        .rdata_o    ( mem_rdata    )
    );

    always_comb begin
        case (wb_src)
            WB_MEM:      wb_data = mem_rdata;
            WB_PC_PLUS4: wb_data = pc_plus4;   // Link address for JAL/JALR
            default:     wb_data = alu_result;
        endcase
    end

    assign imem_addr_o = pc;

    // Retire trace, writes to x0 included
    assign wb_en_o   = reg_we & arst_n_i;
    assign wb_rd_o   = rd;
    assign wb_data_o = wb_data;

endmodule

`default_nettype wire

/* testbench/cpu_props.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_props (
    input logic             clk_i,
    input logic             arst_n_i,
    input logic [`XLEN-1:0] imem_addr_i,
    input logic [`XLEN-1:0] imem_data_i,
    input logic             wb_en_i
);

    logic [6:0] opcode;
    logic       is_flow;

    assign opcode  = imem_data_i[6:0];
    // JAL, JALR and branches
    assign is_flow = (opcode == 7'b1101111) || (opcode == 7'b1100111) ||
                     (opcode == 7'b1100011);

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        imem_addr_i[1:0] == 2'b00)
        else $error("Fetch address is not word aligned");

    a_no_wb_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !wb_en_i)
        else $error("Write-back trace active while reset is held");

    a_pc_zero_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> imem_addr_i == '0)
        else $error("PC is not zero during reset");

    a_pc_sequential: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !is_flow |=> imem_addr_i == $past(imem_addr_i) + `XLEN'd4)
        else $error("PC did not advance by 4 after a non-jump instruction");

endmodule

bind cpu_top cpu_props i_cpu_props (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .imem_addr_i ( imem_addr_o ),
    .imem_data_i ( imem_data_i ),
    .wb_en_i     ( wb_en_o     )
);

`default_nettype wire

/* testbench/cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_BR    = 7'b1100011;
    localparam logic [6:0] OP_LD    = 7'b0000011;
    localparam logic [6:0] OP_ST    = 7'b0100011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;
    localparam int DATA_BASE = `DMEM_WORDS;   // Byte address well inside the data memory

    logic                   clk_i;
    logic                   arst_n_i;
    logic [`XLEN-1:0]       imem_addr_o;
    logic [`XLEN-1:0]       imem_data_i;
    logic                   wb_en_o;
    logic [`REG_ADDR_W-1:0] wb_rd_o;
    logic [`XLEN-1:0]       wb_data_o;

    logic [31:0]            rom [0:63];
    int                     rom_len;
    logic [`REG_ADDR_W-1:0] exp_rd [$];
    logic [`XLEN-1:0]       exp_val [$];
    int                     exp_grp [$];
    string                  group_name [0:5];
    int                     cur_grp;
    int                     exp_idx;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     grp_cnt;
    int                     grp_err;
    int                     cycles;
    int                     limit;
    logic [`XLEN-1:0]       end_addr;
    logic                   end_seen;

    cpu_top i_cpu_top (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .imem_addr_o ( imem_addr_o ),
        .imem_data_i ( imem_data_i ),
        .wb_en_o     ( wb_en_o     ),
        .wb_rd_o     ( wb_rd_o     ),
        .wb_data_o   ( wb_data_o   )
    );

    // Combinational program ROM returning NOP past the end
    assign imem_data_i = (imem_addr_o < 4 * rom_len) ? rom[imem_addr_o[7:2]] : NOP_INSTR;

    always #20 clk_i = ~clk_i;

    // Builds an I, S, B, U or J format word from the full immediate value
    function automatic logic [31:0] enc(input imm_type_e fmt, input logic [6:0] opc,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [31:0] imm);
        logic [31:0] word;
        case (fmt)
            IMM_S:   word = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
            IMM_B:   word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
            IMM_U:   word = {imm[31:12], rd, opc};
            IMM_J:   word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
            default: word = {imm[11:0], rs1, f3, rd, opc};
        endcase
        return word;
    endfunction

    // Register-register ALU group
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    task automatic put_instr(input logic [31:0] word);
        rom[rom_len] = word;
        rom_len++;
    endtask

    task automatic put_instr_wb(input logic [31:0] word, input logic [4:0] rd,
                                input logic [31:0] val);
        put_instr(word);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
        exp_grp.push_back(cur_grp);
    endtask

    // Taken branch skips its ADDI while the not-taken one falls into it
    task automatic branch_pair(input logic [2:0] f3, input logic [4:0] t1, input logic [4:0] t2,
                               input logic [4:0] n1, input logic [4:0] n2, input int k);
        put_instr(enc(IMM_B, OP_BR, f3, 0, t1, t2, 8));
        put_instr(enc(IMM_I, OP_IMM, 3'd0, 25, 0, 0, k));
        put_instr(enc(IMM_B, OP_BR, f3, 0, n1, n2, 8));
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd0, 25, 0, 0, k + 1), 25, k + 1);
    endtask

    task automatic check_wb();
        int   g;
        logic ok;
        if (exp_idx >= exp_rd.size()) begin
            $display("Unexpected write-back to x%0d at %0t after the last expected one",
                     wb_rd_o, $time);
            fail_cnt++;
        end else begin
            g  = exp_grp[exp_idx];
            ok = (wb_rd_o == exp_rd[exp_idx]) && (wb_data_o == exp_val[exp_idx]);
            assert (ok) pass_cnt++;
            else begin
                $display("** Error at %0t: x%0d = 0x%08h, expected x%0d = 0x%08h", $time,
                         wb_rd_o, wb_data_o, exp_rd[exp_idx], exp_val[exp_idx]);
                fail_cnt++;
                grp_err++;
            end
            grp_cnt++;
            exp_idx++;
            if (exp_idx == exp_rd.size() || exp_grp[exp_idx] != g) begin
                $display("Test %s done: %0d write-backs, %0d errors", group_name[g],
                         grp_cnt, grp_err);
                grp_cnt = 0;
                grp_err = 0;
            end
        end
    endtask

    task automatic finish_run();
        if (exp_idx != exp_rd.size()) begin
            $display("Only %0d of %0d expected write-backs were seen", exp_idx, exp_rd.size());
            fail_cnt++;
        end
        $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    always @(posedge clk_i) begin
        if (arst_n_i) begin
            cycles++;
            if (imem_addr_o == end_addr && end_seen) begin
                finish_run();   // Final loop fetched the second time
            end else if (cycles > limit) begin
                $display("Timeout: the program did not reach its final loop in %0d cycles",
                         limit);
                $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
                $display("Simulation finished: FAIL");
                $finish;
            end else begin
                if (imem_addr_o == end_addr) begin
                    end_seen = 1'b1;
                end
                if (wb_en_o) begin
                    check_wb();
                end
            end
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk_i    = 1'b0;
        arst_n_i = 1'b1;
        rom_len  = 0;
        exp_idx  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        grp_cnt  = 0;
        grp_err  = 0;
        cycles   = 0;
        end_seen = 1'b0;
        end_addr = '1;
        limit    = 0;
        group_name = '{"alu", "upper immediate", "load/store", "branch", "jump", "x0"};

        cur_grp = 0;   // x1 = -7 and x2 = 3 are the operands from here on
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd0, 1, 0, 0, -7), 1, 32'hffff_fff9);
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd0, 2, 0, 0, 3), 2, 32'h0000_0003);
        put_instr_wb(enc_r(7'h00, 3'd0, 3, 1, 2), 3, 32'hffff_fffc);
        put_instr_wb(enc_r(7'h20, 3'd0, 4, 2, 1), 4, 32'h0000_000a);
        put_instr_wb(enc_r(7'h00, 3'd7, 5, 1, 2), 5, 32'h0000_0001);
        put_instr_wb(enc_r(7'h00, 3'd6, 6, 1, 2), 6, 32'hffff_fffb);
        put_instr_wb(enc_r(7'h00, 3'd4, 7, 1, 2), 7, 32'hffff_fffa);
        put_instr_wb(enc_r(7'h00, 3'd1, 8, 1, 2), 8, 32'hffff_ffc8);
        put_instr_wb(enc_r(7'h00, 3'd5, 9, 1, 2), 9, 32'h1fff_ffff);
        put_instr_wb(enc_r(7'h20, 3'd5, 10, 1, 2), 10, 32'hffff_ffff);
        put_instr_wb(enc_r(7'h00, 3'd2, 11, 1, 2), 11, 32'h0000_0001);
        put_instr_wb(enc_r(7'h00, 3'd3, 12, 1, 2), 12, 32'h0000_0000);
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd5, 13, 1, 0, 32'h401), 13, 32'hffff_fffc);

        cur_grp = 1;
        put_instr_wb(enc(IMM_U, OP_LUI, 3'd0, 14, 0, 0, 32'h1234_5000), 14, 32'h1234_5000);
        put_instr_wb(enc(IMM_U, OP_AUIPC, 3'd0, 15, 0, 0, 32'h0000_1000), 15, 32'h0000_1038);

        cur_grp = 2;
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd0, 16, 0, 0, DATA_BASE), 16, DATA_BASE);
        put_instr_wb(enc(IMM_U, OP_LUI, 3'd0, 17, 0, 0, 32'h89ab_d000), 17, 32'h89ab_d000);
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd0, 17, 17, 0, -529), 17, 32'h89ab_cdef);
        put_instr(enc(IMM_S, OP_ST, 3'd2, 0, 16, 17, 0));
        put_instr_wb(enc(IMM_I, OP_LD, 3'd2, 18, 16, 0, 0), 18, 32'h89ab_cdef);
        put_instr(enc(IMM_S, OP_ST, 3'd2, 0, 16, 0, 4));
        put_instr(enc(IMM_S, OP_ST, 3'd0, 0, 16, 1, 5));    // Byte 1 = 0xf9
        put_instr(enc(IMM_S, OP_ST, 3'd1, 0, 16, 17, 6));   // Upper half = 0xcdef
        put_instr_wb(enc(IMM_I, OP_LD, 3'd2, 19, 16, 0, 4), 19, 32'hcdef_f900);
        put_instr_wb(enc(IMM_I, OP_LD, 3'd0, 20, 16, 0, 5), 20, 32'hffff_fff9);
        put_instr_wb(enc(IMM_I, OP_LD, 3'd4, 21, 16, 0, 5), 21, 32'h0000_00f9);
        put_instr_wb(enc(IMM_I, OP_LD, 3'd1, 22, 16, 0, 6), 22, 32'hffff_cdef);
        put_instr_wb(enc(IMM_I, OP_LD, 3'd5, 23, 16, 0, 6), 23, 32'h0000_cdef);
        put_instr_wb(enc(IMM_I, OP_LD, 3'd0, 24, 16, 0, 4), 24, 32'h0000_0000);

        cur_grp = 3;
        branch_pair(3'd0, 2, 2, 1, 2, 1);    // BEQ
        branch_pair(3'd1, 1, 2, 2, 2, 3);    // BNE
        branch_pair(3'd4, 1, 2, 2, 1, 5);    // BLT
        branch_pair(3'd5, 2, 1, 1, 2, 7);    // BGE
        branch_pair(3'd6, 2, 1, 1, 2, 9);    // BLTU
        branch_pair(3'd7, 1, 2, 2, 1, 11);   // BGEU

        cur_grp = 4;
        put_instr_wb(enc(IMM_J, OP_JAL, 3'd0, 26, 0, 0, 8), 26, 32'd216);
        put_instr(enc(IMM_I, OP_IMM, 3'd0, 27, 0, 0, 1));
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd0, 28, 0, 0, 229), 28, 32'd229);
        put_instr_wb(enc(IMM_I, OP_JALR, 3'd0, 29, 28, 0, 4), 29, 32'd228);   // Target 233
        put_instr(enc(IMM_I, OP_IMM, 3'd0, 27, 0, 0, 2));
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd0, 27, 0, 0, 3), 27, 32'd3);

        cur_grp = 5;
        put_instr_wb(enc(IMM_I, OP_IMM, 3'd0, 0, 0, 0, 55), 0, 32'd55);
        put_instr_wb(enc_r(7'h00, 3'd0, 30, 0, 2), 30, 32'd3);
        put_instr_wb(enc(IMM_J, OP_JAL, 3'd0, 0, 0, 0, 0), 0, 32'd248);   // Jump to itself

        end_addr = 4 * (rom_len - 1);
        limit    = 4 * rom_len;

        #2 arst_n_i = 1'b0;   // Falling edge fires the async reset
        repeat (8) @(posedge clk_i);
        #2 arst_n_i = 1'b1;
    end

endmodule

`default_nettype wire

/* cpu.f */
+incdir+.
verilog/cpu_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/data_memory.sv
verilog/cpu_top.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

/* Makefile */
SIM = obj_dir/Vcpu_tb

.PHONY: all run clean

all: run

$(SIM): cpu.f cpu_defines.svh $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -f cpu.f --top-module cpu_tb \
		-Mdir obj_dir -o Vcpu_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
